/* Makefile */
# Verilator build and run for the AXI memory subsystem testbench

SIM := obj_dir/Vaxi_mem_tb

# rebuilt only when a source or the file list changes
$(SIM): vlog.f $(wildcard hdl/*.sv test/*.sv include/*.svh)
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  --top-module axi_mem_tb -f vlog.f -o Vaxi_mem_tb

run: $(SIM)
	$(SIM) | tee sim.log
	@if grep -qF '*** TEST FAILED ***' sim.log; then exit 1; fi
	@grep -qF '*** TEST PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

/* hdl/axi_fifo_pkg.sv */
// channel payload types for the AXI-to-FIFO memory subsystem
// import with axi_fifo_pkg::* in the module header of any block that uses them
`default_nettype none

`include "axi_fifo_consts.svh"

package axi_fifo_pkg;

  // address channel, shared by AW and AR
  typedef struct packed {
    logic [`AXI_ADDR_W-1:0] addr;
    logic [`AXI_ID_W-1:0]   id;
    // log2 of bytes per beat
    logic [2:0]             size;
  } axi_ax_t;

  // write data channel, wlast is implied
  typedef struct packed {
    logic [`AXI_DATA_W-1:0] data;
    logic [`AXI_STRB_W-1:0] strb;
  } axi_w_t;

  // write response channel
  typedef struct packed {
    logic [`AXI_ID_W-1:0] id;
    logic [1:0]           resp;
  } axi_b_t;

  // read data channel
  typedef struct packed {
    logic [`AXI_ID_W-1:0]   id;
    logic [`AXI_DATA_W-1:0] data;
    logic [1:0]             resp;
    logic                   last;
  } axi_r_t;

  // serialized request toward the memory
  typedef struct packed {
    logic [`AXI_ADDR_W-1:0] addr;
    logic [`AXI_DATA_W-1:0] data;
    logic [`AXI_STRB_W-1:0] wmask;
    logic [2:0]             size;
    // set for a write, clear for a read
    logic                   w;
  } fifo_req_t;

  // in-order response from the memory
  typedef struct packed {
    logic [`AXI_DATA_W-1:0] data;
    logic                   w;
  } fifo_rsp_t;

endpackage

`default_nettype wire

/* hdl/axi_mem_subsystem.sv */
// top level of the AXI4 memory subsystem
// the bridge serializes the five AXI channels into requests for the scratch memory
// completion shows up as bvalid or rvalid, latency varies
`timescale 1ns/1ps
`default_nettype none

module axi_mem_subsystem
  import axi_fifo_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  axi_ax_t aw_i,
  input  logic    aw_valid_i,
  output logic    aw_ready_o,
  input  axi_w_t  w_i,
  input  logic    w_valid_i,
  output logic    w_ready_o,
  output axi_b_t  b_o,
  output logic    b_valid_o,
  input  logic    b_ready_i,
  input  axi_ax_t ar_i,
  input  logic    ar_valid_i,
  output logic    ar_ready_o,
  output axi_r_t  r_o,
  output logic    r_valid_o,
  input  logic    r_ready_i
);

  fifo_req_t req;
  fifo_rsp_t rsp;
  logic      req_v;
  logic      req_ready;
  logic      rsp_v;
  logic      rsp_ready;

  axi_to_fifo_bridge i_bridge (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .aw_i        (aw_i),
    .aw_valid_i  (aw_valid_i),
    .aw_ready_o  (aw_ready_o),
    .w_i         (w_i),
    .w_valid_i   (w_valid_i),
    .w_ready_o   (w_ready_o),
    .b_o         (b_o),
    .b_valid_o   (b_valid_o),
    .b_ready_i   (b_ready_i),
    .ar_i        (ar_i),
    .ar_valid_i  (ar_valid_i),
    .ar_ready_o  (ar_ready_o),
    .r_o         (r_o),
    .r_valid_o   (r_valid_o),
    .r_ready_i   (r_ready_i),
    .req_o       (req),
    .req_v_o     (req_v),
    .req_ready_i (req_ready),
    .rsp_i       (rsp),
    .rsp_v_i     (rsp_v),
    .rsp_ready_o (rsp_ready)
  );

  scratch_memory i_mem (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (req),
    .req_v_i     (req_v),
    .req_ready_o (req_ready),
    .rsp_o       (rsp),
    .rsp_ready_i (rsp_ready),
    .rsp_v_o     (rsp_v)
  );

endmodule

`default_nettype wire

/* hdl/axi_to_fifo_bridge.sv */
// AXI4 subordinate to FIFO request/response bridge, single transfers only
// AW+W and AR are buffered and serialized into one request stream, reads first
// responses must come back in order, one per request
`timescale 1ns/1ps
`default_nettype none

`include "axi_fifo_consts.svh"

module axi_to_fifo_bridge
  import axi_fifo_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  axi_ax_t   aw_i,
  input  logic      aw_valid_i,
  output logic      aw_ready_o,
  input  axi_w_t    w_i,
  input  logic      w_valid_i,
  output logic      w_ready_o,
  output axi_b_t    b_o,
  output logic      b_valid_o,
  input  logic      b_ready_i,
  input  axi_ax_t   ar_i,
  input  logic      ar_valid_i,
  output logic      ar_ready_o,
  output axi_r_t    r_o,
  output logic      r_valid_o,
  input  logic      r_ready_i,
  output fifo_req_t req_o,
  output logic      req_v_o,
  input  logic      req_ready_i,
  input  fifo_rsp_t rsp_i,
  input  logic      rsp_v_i,
  output logic      rsp_ready_o
);

  axi_ax_t   aw_q;
  axi_ax_t   ar_q;
  axi_w_t    w_q;
  fifo_rsp_t rsp_q;
  logic      aw_v;
  logic      w_v;
  logic      ar_v;
  logic      rsp_v;
  logic      b_hs;
  logic      r_hs;
  logic      out_q;

  // aw, w and ar stay buffered until their B or R goes out
  one_slot_buffer #(.payload_t(axi_ax_t)) i_aw_buf (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .data_i  (aw_i),
    .v_i     (aw_valid_i),
    .ready_o (aw_ready_o),
    .data_o  (aw_q),
    .v_o     (aw_v),
    .yumi_i  (b_hs)
  );

  one_slot_buffer #(.payload_t(axi_w_t)) i_w_buf (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .data_i  (w_i),
    .v_i     (w_valid_i),
    .ready_o (w_ready_o),
    .data_o  (w_q),
    .v_o     (w_v),
    .yumi_i  (b_hs)
  );

  one_slot_buffer #(.payload_t(axi_ax_t)) i_ar_buf (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .data_i  (ar_i),
    .v_i     (ar_valid_i),
    .ready_o (ar_ready_o),
    .data_o  (ar_q),
    .v_o     (ar_v),
    .yumi_i  (r_hs)
  );

  // every issued request lands here before becoming B or R
  one_slot_buffer #(.payload_t(fifo_rsp_t)) i_rsp_buf (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .data_i  (rsp_i),
    .v_i     (rsp_v_i),
    .ready_o (rsp_ready_o),
    .data_o  (rsp_q),
    .v_o     (rsp_v),
    .yumi_i  (b_hs | r_hs)
  );

  // issue only with room for the response and nothing in flight
  assign req_v_o = rsp_ready_o & ~out_q & (ar_v | (aw_v & w_v));

  // read wins when both are ready
  always_comb begin
    req_o.addr  = ar_v ? ar_q.addr : aw_q.addr;
    req_o.size  = ar_v ? ar_q.size : aw_q.size;
    req_o.data  = w_q.data;
    req_o.wmask = w_q.strb;
    req_o.w     = ~ar_v;
  end

  // blocks a second issue of the same buffered request
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_q <= 1'b0;
    end else if (req_v_o && req_ready_i) begin
      out_q <= 1'b1;
    end else if (rsp_v_i && rsp_ready_o) begin
      out_q <= 1'b0;
    end
  end

  // route buffered response by its write bit
  assign b_valid_o = rsp_v & rsp_q.w;
  assign r_valid_o = rsp_v & ~rsp_q.w;
  assign b_hs      = b_valid_o & b_ready_i;
  assign r_hs      = r_valid_o & r_ready_i;

  always_comb begin
    b_o.id   = aw_q.id;
    b_o.resp = `AXI_RESP_OKAY;
    r_o.id   = ar_q.id;
    r_o.data = rsp_q.data;
    r_o.resp = `AXI_RESP_OKAY;
    // single transfers only
    r_o.last = 1'b1;
  end

  a_aw_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    aw_v |-> (aw_q.size <= 3'd3) && ((aw_q.addr[2:0] & ~(3'b111 << aw_q.size)) == 3'b0));

  a_ar_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ar_v |-> (ar_q.size <= 3'd3) && ((ar_q.addr[2:0] & ~(3'b111 << ar_q.size)) == 3'b0));

  // memory answers only what was issued
  a_rsp_expected: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_v_i |-> out_q);

endmodule

`default_nettype wire

/* hdl/one_slot_buffer.sv */
// single-entry buffer, valid/ready on the input side and valid/yumi on the output
// the consumer raises yumi_i only while v_o is high to free the slot
`timescale 1ns/1ps
`default_nettype none

module one_slot_buffer
  import axi_fifo_pkg::*;
#(
  parameter type payload_t = axi_b_t
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  payload_t data_i,
  input  logic     v_i,
  output logic     ready_o,
  output payload_t data_o,
  output logic     v_o,
  input  logic     yumi_i
);

  logic     full_q;
  payload_t data_q;

  // accept only into an empty slot
  assign ready_o = ~full_q;
  assign v_o     = full_q;
  assign data_o  = data_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
    end else if (v_i && ready_o) begin
      full_q <= 1'b1;
    end else if (yumi_i) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (v_i && ready_o) begin
      data_q <= data_i;
    end
  end

  // consumer must not dequeue an empty slot
  a_yumi_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    yumi_i |-> v_o);

endmodule

`default_nettype wire

/* hdl/scratch_memory.sv */
// word-addressed scratch memory serving the bridge's FIFO request stream
// one response per request, registered, valid the edge after acceptance
// addresses past the end alias back modulo the depth
`timescale 1ns/1ps
`default_nettype none

`include "axi_fifo_consts.svh"

module scratch_memory
  import axi_fifo_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  fifo_req_t req_i,
  input  logic      req_v_i,
  output logic      req_ready_o,
  output fifo_rsp_t rsp_o,
  input  logic      rsp_ready_i,
  output logic      rsp_v_o
);

  localparam int IDX_W = $clog2(`MEM_DEPTH);

  logic [`AXI_DATA_W-1:0] mem_q [`MEM_DEPTH];
  logic [IDX_W-1:0]       idx;
  logic                   accept;
  logic                   rsp_v_q;
  fifo_rsp_t              rsp_q;

  // word index, byte offset bits dropped
  assign idx = req_i.addr[IDX_W+2:3];

  // stall while a response is still waiting
  assign req_ready_o = ~rsp_v_q;
  assign accept      = req_v_i & req_ready_o;

  assign rsp_o   = rsp_q;
  assign rsp_v_o = rsp_v_q;

  // byte-masked write, lanes already placed by the master
  always_ff @(posedge clk_i) begin
    if (accept && req_i.w) begin
      for (int b = 0; b < `AXI_STRB_W; b++) begin
        if (req_i.wmask[b]) begin
          mem_q[idx][b*8 +: 8] <= req_i.data[b*8 +: 8];
        end
      end
    end
  end

  // read data is the whole word, old contents on a write
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_q.data <= mem_q[idx];
      rsp_q.w    <= req_i.w;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_v_q <= 1'b0;
    end else if (accept) begin
      rsp_v_q <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_v_q <= 1'b0;
    end
  end

  // narrow accesses must sit on their natural boundary
  a_req_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    accept |-> (req_i.addr[2:0] & ~(3'b111 << req_i.size)) == 3'b0);

endmodule

`default_nettype wire

/* include/axi_fifo_consts.svh */
// widths and fixed codes shared by the AXI memory subsystem
// include it in any file that sizes a port, a struct or the memory array
`ifndef AXI_FIFO_CONSTS_SVH
`define AXI_FIFO_CONSTS_SVH

// AXI data bus, one 64-bit word per beat
`define AXI_DATA_W 64

// byte address width
`define AXI_ADDR_W 32

// transaction ID width
`define AXI_ID_W 2

// one strobe bit per data byte
`define AXI_STRB_W 8

// scratch memory depth in 64-bit words
`define MEM_DEPTH 256

// only OKAY is ever returned
`define AXI_RESP_OKAY 2'b00

`endif

/* test/axi_mem_tb.sv */
// testbench for the AXI4 memory subsystem
// drives single AXI transfers, keeps a reference copy of the memory and checks
// every B and R beat against it, built and run through the Makefile
`timescale 1ns/1ps
`default_nettype none

`include "axi_fifo_consts.svh"

module axi_mem_tb
  import axi_fifo_pkg::*;
();

  localparam int RESET_CYCLES = 16;
  // 2 + 6 + 4 + 64 + 4 transactions over tests 2 to 6
  localparam int NUM_TRANS    = 80;
  localparam int CYCLE_LIMIT  = NUM_TRANS * 200 + RESET_CYCLES;
  localparam int IDX_W        = $clog2(`MEM_DEPTH);

  logic    clk_i;
  logic    rst_n_i;
  axi_ax_t aw_i;
  logic    aw_valid_i;
  logic    aw_ready_o;
  axi_w_t  w_i;
  logic    w_valid_i;
  logic    w_ready_o;
  axi_b_t  b_o;
  logic    b_valid_o;
  logic    b_ready_i;
  axi_ax_t ar_i;
  logic    ar_valid_i;
  logic    ar_ready_o;
  axi_r_t  r_o;
  logic    r_valid_o;
  logic    r_ready_i;

  // reference memory and expected responses, in order per channel
  logic [`AXI_DATA_W-1:0] model_mem [`MEM_DEPTH];
  logic                   model_written [`MEM_DEPTH];
  logic [`AXI_ID_W-1:0]   exp_b_q [$];
  logic [`AXI_ID_W-1:0]   exp_r_id_q [$];
  logic [`AXI_DATA_W-1:0] exp_r_data_q [$];
  logic [`AXI_ID_W-1:0]   exp_id;
  logic [`AXI_DATA_W-1:0] exp_data;
  integer                 seed;
  int                     errors;
  int                     writes;
  int                     reads;
  int                     b_seen;
  int                     r_seen;
  int                     cycles;
  logic                   stall_en;

  axi_mem_subsystem i_axi_mem_subsystem (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // word index is the address above the byte offset, modulo the depth
  function automatic logic [IDX_W-1:0] word_index(input logic [`AXI_ADDR_W-1:0] addr);
    logic [`AXI_ADDR_W-1:0] full_idx;
    full_idx = (addr >> 3) % `MEM_DEPTH;
    return full_idx[IDX_W-1:0];
  endfunction

  // reference merge, only strobed bytes take the new data
  function automatic logic [63:0] merge_strobed(input logic [63:0] old_word,
                                                input logic [63:0] new_data,
                                                input logic [7:0] strb);
    logic [63:0] result;
    result = old_word;
    for (int i = 0; i < 8; i++) begin
      if (strb[i]) begin
        result[i*8 +: 8] = new_data[i*8 +: 8];
      end
    end
    return result;
  endfunction

  // strobes for a narrow beat at an aligned byte offset
  function automatic logic [7:0] lane_strobe(input logic [2:0] size, input logic [2:0] off);
    logic [15:0] ones;
    ones = (16'd1 << (4'd1 << size)) - 16'd1;
    return ones[7:0] << off;
  endfunction

  task automatic apply_write(input logic [`AXI_ADDR_W-1:0] addr,
                             input logic [`AXI_DATA_W-1:0] data,
                             input logic [`AXI_STRB_W-1:0] strb);
    logic [IDX_W-1:0] idx;
    idx = word_index(addr);
    model_mem[idx]     = merge_strobed(model_mem[idx], data, strb);
    model_written[idx] = 1'b1;
  endtask

  // holds each valid until its handshake, called 2 ns after a rising edge
  task automatic drive_channels(input logic wr, input logic rd, input axi_ax_t aw,
                                input axi_w_t w, input axi_ax_t ar);
    logic aw_done;
    logic w_done;
    logic ar_done;
    aw_done    = !wr;
    w_done     = !wr;
    ar_done    = !rd;
    aw_i       = aw;
    w_i        = w;
    ar_i       = ar;
    aw_valid_i = wr;
    w_valid_i  = wr;
    ar_valid_i = rd;
    while (!(aw_done && w_done && ar_done)) begin
      @(negedge clk_i);
      aw_done = aw_done | aw_ready_o;
      w_done  = w_done | w_ready_o;
      ar_done = ar_done | ar_ready_o;
      @(posedge clk_i);
      #2;
      aw_valid_i = !aw_done;
      w_valid_i  = !w_done;
      ar_valid_i = !ar_done;
    end
  endtask

  task automatic wait_idle();
    do begin
      @(posedge clk_i);
    end while (exp_b_q.size() + exp_r_id_q.size() != 0);
    #2;
  endtask

  task automatic write_beat(input logic [`AXI_ADDR_W-1:0] addr, input logic [1:0] id,
                            input logic [2:0] size, input logic [`AXI_DATA_W-1:0] data,
                            input logic [`AXI_STRB_W-1:0] strb);
    apply_write(addr, data, strb);
    exp_b_q.push_back(id);
    writes++;
    // concatenations follow the packed field order
    drive_channels(1'b1, 1'b0, {addr, id, size}, {data, strb}, '0);
    wait_idle();
  endtask

  task automatic read_beat(input logic [`AXI_ADDR_W-1:0] addr, input logic [1:0] id,
                           input logic [2:0] size);
    exp_r_id_q.push_back(id);
    exp_r_data_q.push_back(model_mem[word_index(addr)]);
    reads++;
    drive_channels(1'b0, 1'b1, '0, '0, {addr, id, size});
    wait_idle();
  endtask

  task automatic report_test(input string name, input int err_mark);
    assert (b_seen == writes && r_seen == reads) else begin
      $display("response count mismatch after %0s: %0d B for %0d writes, %0d R for %0d reads",
               name, b_seen, writes, r_seen, reads);
      errors++;
    end
    if (errors == err_mark) begin
      $display("test %0s: ok", name);
    end else begin
      $display("test %0s: %0d errors", name, errors - err_mark);
    end
  endtask

  // random bready/rready stalls, only while enabled
  initial begin : ready_stalls
    logic [31:0] rnd;
    b_ready_i = 1'b1;
    r_ready_i = 1'b1;
    forever begin
      @(posedge clk_i);
      #2;
      rnd       = $random(seed);
      b_ready_i = !stall_en || rnd[1:0] != 2'b00;
      r_ready_i = !stall_en || rnd[3:2] != 2'b00;
    end
  end

  // handshakes are decided by the next rising edge, so sample at the falling one
  initial begin
    forever begin
      @(negedge clk_i);
      if (b_valid_o && b_ready_i) begin
        b_seen++;
        if (exp_b_q.size() == 0) begin
          $display("B beat at %0t with no write outstanding", $time);
          errors++;
        end else begin
          exp_id = exp_b_q.pop_front();
          assert (b_o.id == exp_id && b_o.resp == `AXI_RESP_OKAY) else begin
            $display("** Error at %0t: B id %0d resp %0d, expected id %0d resp OKAY",
                     $time, b_o.id, b_o.resp, exp_id);
            errors++;
          end
        end
      end
      if (r_valid_o && r_ready_i) begin
        r_seen++;
        if (exp_r_id_q.size() == 0) begin
          $display("R beat at %0t with no read outstanding", $time);
          errors++;
        end else begin
          exp_id   = exp_r_id_q.pop_front();
          exp_data = exp_r_data_q.pop_front();
          assert (r_o.id == exp_id && r_o.resp == `AXI_RESP_OKAY && r_o.last) else begin
            $display("** Error at %0t: R id %0d resp %0d last %0b, expected id %0d OKAY last",
                     $time, r_o.id, r_o.resp, r_o.last, exp_id);
            errors++;
          end
          assert (r_o.data == exp_data) else begin
            $display("** Error at %0t: R data %h, expected %h", $time, r_o.data, exp_data);
            errors++;
          end
        end
      end
    end
  end

  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout: transactions still pending after %0d cycles", cycles);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin : main_sequence
    int                     err_mark;
    logic [31:0]            rnd_a;
    logic [31:0]            rnd_b;
    logic [31:0]            rnd_c;
    logic [2:0]             size;
    logic [2:0]             off;
    logic [`AXI_ADDR_W-1:0] addr;
    seed          = 24460;
    errors        = 0;
    writes        = 0;
    reads         = 0;
    b_seen        = 0;
    r_seen        = 0;
    stall_en      = 1'b0;
    rst_n_i       = 1'b0;
    aw_i          = '0;
    w_i           = '0;
    ar_i          = '0;
    aw_valid_i    = 1'b0;
    w_valid_i     = 1'b0;
    ar_valid_i    = 1'b0;
    model_mem     = '{default: '0};
    model_written = '{default: 1'b0};
    repeat (RESET_CYCLES) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;

    err_mark = errors;
    @(negedge clk_i);
    assert (!b_valid_o && !r_valid_o && aw_ready_o && w_ready_o && ar_ready_o) else begin
      $display("** Error at %0t: bad state after reset", $time);
      errors++;
    end
    @(posedge clk_i);
    #2;
    report_test("reset state", err_mark);

    err_mark = errors;
    write_beat(32'h40, 2'd1, 3'd3, 64'h0123_4567_89ab_cdef, 8'hff);
    read_beat(32'h40, 2'd2, 3'd3);
    report_test("write then read", err_mark);

    // byte, half, word and sparse double merges into one word
    err_mark = errors;
    write_beat(32'h88, 2'd0, 3'd3, 64'h1122_3344_5566_7788, 8'hff);
    write_beat(32'h8b, 2'd1, 3'd0, 64'hdead_beef_cafe_f00d, 8'h08);
    write_beat(32'h8e, 2'd2, 3'd1, 64'ha5a5_5a5a_0f0f_f0f0, 8'hc0);
    write_beat(32'h88, 2'd3, 3'd2, 64'h9999_aaaa_bbbb_cccc, 8'h0f);
    write_beat(32'h88, 2'd0, 3'd3, 64'h0102_0304_0506_0708, 8'h24);
    read_beat(32'h88, 2'd1, 3'd3);
    report_test("partial writes", err_mark);

    // read and write to one word in the same cycle, the read goes first
    err_mark = errors;
    write_beat(32'h100, 2'd0, 3'd3, 64'h5555_6666_7777_8888, 8'hff);
    exp_r_id_q.push_back(2'd2);
    exp_r_data_q.push_back(model_mem[word_index(32'h100)]);
    apply_write(32'h100, 64'hfeed_face_0bad_c0de, 8'hff);
    exp_b_q.push_back(2'd3);
    writes++;
    reads++;
    drive_channels(1'b1, 1'b1, {32'h100, 2'd3, 3'd3}, {64'hfeed_face_0bad_c0de, 8'hff},
                   {32'h100, 2'd2, 3'd3});
    wait_idle();
    read_beat(32'h100, 2'd1, 3'd3);
    report_test("read priority", err_mark);

    // words 16 to 31, unwritten words get a full write first
    err_mark = errors;
    stall_en = 1'b1;
    for (int n = 0; n < 64; n++) begin
      rnd_a = $random(seed);
      rnd_b = $random(seed);
      rnd_c = $random(seed);
      size  = {1'b0, rnd_a[9:8]};
      off   = rnd_a[2:0] & ~((3'd1 << size) - 3'd1);
      addr  = {24'd0, 1'b1, rnd_a[7:4], off};
      if (!model_written[word_index(addr)]) begin
        write_beat({24'd0, 1'b1, rnd_a[7:4], 3'd0}, rnd_a[11:10], 3'd3, {rnd_b, rnd_c}, 8'hff);
      end else if (rnd_a[12]) begin
        read_beat(addr, rnd_a[11:10], size);
      end else if (size == 3'd3) begin
        write_beat(addr, rnd_a[11:10], size, {rnd_b, rnd_c}, rnd_c[7:0]);
      end else begin
        write_beat(addr, rnd_a[11:10], size, {rnd_b, rnd_c}, lane_strobe(size, off));
      end
    end
    stall_en = 1'b0;
    report_test("random traffic", err_mark);

    // addresses one and two depths up land on words 5 and 6
    err_mark = errors;
    write_beat(32'((`MEM_DEPTH + 5) * 8), 2'd3, 3'd3, 64'hc001_d00d_1234_5678, 8'hff);
    read_beat(32'h28, 2'd0, 3'd3);
    write_beat(32'h30, 2'd1, 3'd3, 64'h8765_4321_abcd_ef01, 8'hff);
    read_beat(32'((2 * `MEM_DEPTH + 6) * 8), 2'd2, 3'd3);
    report_test("address wrap", err_mark);

    $display("done: %0d writes, %0d reads, %0d B, %0d R, %0d errors",
             writes, reads, b_seen, r_seen, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+include
hdl/axi_fifo_pkg.sv
hdl/one_slot_buffer.sv
hdl/axi_to_fifo_bridge.sv
hdl/scratch_memory.sv
hdl/axi_mem_subsystem.sv
test/axi_mem_tb.sv
